//--- rtl/pet_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// Shared PET glue logic definitions
// SPI frame, config and bus control structs
// Register addresses and PET memory map
//~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pet_pkg;

    // One 16-bit SPI frame, first byte is the command
    typedef struct packed {
        logic       wr;         // 1 = write, 0 = read
        logic [6:0] addr;       // Register address
        logic [7:0] data;       // Write data (ignored on reads)
    } spi_frame_t;

    // Control register layout, cpu_be is bit 0
    typedef struct packed {
        logic status_led;       // Drives the status LED
        logic video_mirror;     // Fold video RAM into 1 KB
        logic rom_wp;           // Block writes to ROM region
        logic cpu_be;           // CPU bus enable
    } pet_cfg_t;

    localparam pet_cfg_t CFG_RESET = '{status_led: 1'b0, video_mirror: 1'b0,
                                       rom_wp: 1'b1, cpu_be: 1'b0};

    // Decoder outputs, all active high
    typedef struct packed {
        logic ram_oe;
        logic ram_we;
        logic io_oe;
        logic pia1_cs;
        logic pia2_cs;
        logic via_cs;
        logic ram_a16;
        logic ram_a15;
        logic ram_a11;
        logic ram_a10;
    } bus_ctl_t;

    // Register map
    localparam logic [6:0] REG_CTRL   = 7'd0;
    localparam logic [6:0] REG_STATUS = 7'd1;   // Read only straps

    // PET memory map
    localparam logic [15:0] RAM_BASE   = 16'h0000;
    localparam logic [15:0] RAM_END    = 16'h7FFF;
    localparam logic [15:0] VIDEO_BASE = 16'h8000;
    localparam logic [15:0] VIDEO_END  = 16'h8FFF;
    localparam logic [15:0] IO_BASE    = 16'hE800;
    localparam logic [15:0] IO_END     = 16'hEFFF;
    localparam logic [15:0] PIA1_BASE  = 16'hE810;
    localparam logic [15:0] PIA2_BASE  = 16'hE820;
    localparam logic [15:0] VIA_BASE   = 16'hE840;
    localparam int unsigned IO_WIN_BITS = 4;      // 16-byte chip windows

endpackage

`default_nettype wire

//--- rtl/spi_target.sv
//~~~~~~~~~~~~~~~~~~~~
// SPI mode 0 target
// Pin synchronizer, 16-bit frame capture, read-back shifter
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_target import pet_pkg::*; #(
    parameter int unsigned SPI_SYNC_STAGES = 2      // 2 or 3
) (
    input  logic       clock_i,
    input  logic       rst_n_i,
    input  logic       spi_cs_ni,   // Chip select, active low
    input  logic       spi_sck_i,
    input  logic       spi_sd_i,    // MCU -> FPGA
    input  logic [7:0] rd_data_i,   // Register addressed by the command byte
    output logic       spi_sd_o,    // FPGA -> MCU
    output spi_frame_t frame_o,
    output logic       frame_valid_o
);
    localparam logic [2:0] PIN_IDLE = 3'b100;     // CS high, SCK low, SDI low

    logic [SPI_SYNC_STAGES-1:0][2:0] sync_q;      // {cs_n, sck, sd} per stage
    logic       cs_n_s;
    logic       sck_s;
    logic       sd_s;
    logic       sck_q;                            // Previous synced SCK
    logic       sck_rise;
    logic       sck_fall;
    logic [3:0] bit_cnt_q;                        // Rising edges seen, wraps at 16
    logic [6:0] shift_q;                          // Last seven bits received
    logic [7:0] cmd_q;                            // Command byte of current frame
    logic [7:0] data_q;                           // Data byte of last full frame
    logic       valid_q;
    logic [7:0] tx_q;                             // Read-back shift register

    // Bring all three pins into the clock_i domain together
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= {SPI_SYNC_STAGES{PIN_IDLE}};
            sck_q  <= 1'b0;
        end else begin
            sync_q <= {sync_q[SPI_SYNC_STAGES-2:0], {spi_cs_ni, spi_sck_i, spi_sd_i}};
            sck_q  <= sck_s;
        end
    end

    assign {cs_n_s, sck_s, sd_s} = sync_q[SPI_SYNC_STAGES-1];

    // Edges only count while selected
    assign sck_rise = sck_s & ~sck_q & ~cs_n_s;
    assign sck_fall = ~sck_s & sck_q & ~cs_n_s;

    // Bit counter and frame strobe
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt_q <= '0;
            cmd_q     <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;                      // Single clock pulse
            if (cs_n_s) begin
                bit_cnt_q <= '0;                  // Deselect drops a partial frame
            end else if (sck_rise) begin
                bit_cnt_q <= bit_cnt_q + 4'd1;
                if (bit_cnt_q == 4'd7) begin
                    cmd_q <= {shift_q, sd_s};     // Address now steers rd_data_i
                end
                if (bit_cnt_q == 4'd15) begin
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // Incoming data, MSB first
    always_ff @(posedge clock_i) begin
        if (sck_rise) begin
            shift_q <= {shift_q[5:0], sd_s};
            if (bit_cnt_q == 4'd15) begin
                data_q <= {shift_q, sd_s};        // Same edge as valid_q
            end
        end
    end

    // Read-back is loaded on the falling edge after bit 8
    // and shifted on each later falling edge, so the MCU samples on the rise
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_q <= '0;
        end else if (cs_n_s) begin
            tx_q <= '0;                           // SDO idles low
        end else if (sck_fall) begin
            if (bit_cnt_q == 4'd8) begin
                tx_q <= rd_data_i;
            end else begin
                tx_q <= {tx_q[6:0], 1'b0};
            end
        end
    end

    assign spi_sd_o      = tx_q[7];
    assign frame_o       = spi_frame_t'({cmd_q, data_q});
    assign frame_valid_o = valid_q;
endmodule

`default_nettype wire

//--- rtl/pet_config_regs.sv
//~~~~~~~~~~~~~~~~~~~~
// Configuration registers
// Control register write and read-back mux
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pet_config_regs import pet_pkg::*; (
    input  logic       clock_i,
    input  logic       rst_n_i,
    input  spi_frame_t frame_i,
    input  logic       frame_valid_i,
    input  logic       config_crt_i,    // 0 = 12", 1 = 9"
    input  logic       config_kbd_i,    // 0 = Business, 1 = Graphics
    output pet_cfg_t   cfg_o,
    output logic [7:0] rd_data_o
);
    localparam int unsigned CFG_BITS = $bits(pet_cfg_t);

    pet_cfg_t ctrl_q;
    logic     ctrl_wr;

    // Only REG_CTRL is writable
    assign ctrl_wr = frame_valid_i && frame_i.wr && (frame_i.addr == REG_CTRL);

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= CFG_RESET;                  // Bus off, ROM protected
        end else if (ctrl_wr) begin
            ctrl_q <= pet_cfg_t'(frame_i.data[CFG_BITS-1:0]);
        end
    end

    // Read mux follows the command byte held by the target
    always_comb begin
        case (frame_i.addr)
            REG_CTRL: begin
                rd_data_o = {{(8 - CFG_BITS){1'b0}}, ctrl_q};
            end
            REG_STATUS: begin
                rd_data_o = {6'b0, config_kbd_i, config_crt_i};  // Board straps
            end
            default: begin
                rd_data_o = 8'h00;                // Unmapped reads as zero
            end
        endcase
    end

    assign cfg_o = ctrl_q;
endmodule

`default_nettype wire

//--- rtl/pet_addr_decode.sv
//~~~~~~~~~~~~~~~~~~~~
// PET address decoder
// RAM strobes, RAM upper address bits and IO chip selects
// All outputs registered
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pet_addr_decode import pet_pkg::*; (
    input  logic        clock_i,
    input  logic        rst_n_i,
    input  logic [15:0] cpu_addr_i,
    input  logic        cpu_rwb_i,      // 1 = read
    input  pet_cfg_t    cfg_i,
    output bus_ctl_t    bus_o
);
    logic     in_low;                     // RAM or video, below 0x9000
    logic     in_video;
    logic     in_io;
    logic     fold;                       // Video mirror active for this access
    bus_ctl_t bus_d;
    bus_ctl_t bus_q;

    assign in_low   = cpu_addr_i <= VIDEO_END;
    assign in_video = (cpu_addr_i >= VIDEO_BASE) && (cpu_addr_i <= VIDEO_END);
    assign in_io    = (cpu_addr_i >= IO_BASE) && (cpu_addr_i <= IO_END);
    assign fold     = in_video && cfg_i.video_mirror;

    always_comb begin
        bus_d = '0;                           // Nothing selected by default
        if (cfg_i.cpu_be) begin
            if (in_low) begin
                bus_d.ram_oe  = cpu_rwb_i;
                bus_d.ram_we  = !cpu_rwb_i;
                bus_d.ram_a16 = 1'b0;         // Lower 64K bank
                bus_d.ram_a15 = cpu_addr_i[15];
                bus_d.ram_a11 = fold ? 1'b0 : cpu_addr_i[11];
                bus_d.ram_a10 = fold ? 1'b0 : cpu_addr_i[10];
            end else if (in_io) begin
                bus_d.io_oe   = 1'b1;
                // Exact 16-byte windows, gaps select no chip
                bus_d.pia1_cs = cpu_addr_i[15:IO_WIN_BITS] == PIA1_BASE[15:IO_WIN_BITS];
                bus_d.pia2_cs = cpu_addr_i[15:IO_WIN_BITS] == PIA2_BASE[15:IO_WIN_BITS];
                bus_d.via_cs  = cpu_addr_i[15:IO_WIN_BITS] == VIA_BASE[15:IO_WIN_BITS];
            end else begin
                // ROM images live in the upper 64K bank
                bus_d.ram_oe  = cpu_rwb_i;
                bus_d.ram_we  = !cpu_rwb_i && !cfg_i.rom_wp;
                bus_d.ram_a16 = 1'b1;
                bus_d.ram_a15 = cpu_addr_i[15];
                bus_d.ram_a11 = cpu_addr_i[11];
                bus_d.ram_a10 = cpu_addr_i[10];
            end
        end
    end

    // One clock from address to pins
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_q <= '0;
        end else begin
            bus_q <= bus_d;
        end
    end

    assign bus_o = bus_q;
endmodule

`default_nettype wire

//--- rtl/pet_main.sv
//~~~~~~~~~~~~~~~~~~~~
// PET glue core
// SPI target, config registers and address decoder
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pet_main import pet_pkg::*; #(
    parameter int unsigned SPI_SYNC_STAGES = 2
) (
    input  logic        clock_i,
    input  logic        rst_n_i,
    input  logic [15:0] cpu_addr_i,
    input  logic        cpu_rwb_i,
    input  logic        spi1_cs_ni,
    input  logic        spi1_sck_i,
    input  logic        spi1_sd_i,
    input  logic        config_crt_i,
    input  logic        config_kbd_i,
    output bus_ctl_t    bus_o,
    output logic        cpu_be_o,
    output logic        status_o,       // LED on when high
    output logic        spi1_sd_o
);
    spi_frame_t frame;
    logic       frame_valid;
    logic [7:0] rd_data;
    pet_cfg_t   cfg;

    spi_target #(
        .SPI_SYNC_STAGES(SPI_SYNC_STAGES)
    ) spi (
        .clock_i(clock_i),
        .rst_n_i(rst_n_i),
        .spi_cs_ni(spi1_cs_ni),
        .spi_sck_i(spi1_sck_i),
        .spi_sd_i(spi1_sd_i),
        .rd_data_i(rd_data),
        .spi_sd_o(spi1_sd_o),
        .frame_o(frame),
        .frame_valid_o(frame_valid)
    );

    pet_config_regs regs (
        .clock_i(clock_i),
        .rst_n_i(rst_n_i),
        .frame_i(frame),
        .frame_valid_i(frame_valid),
        .config_crt_i(config_crt_i),
        .config_kbd_i(config_kbd_i),
        .cfg_o(cfg),
        .rd_data_o(rd_data)
    );

    pet_addr_decode decode (
        .clock_i(clock_i),
        .rst_n_i(rst_n_i),
        .cpu_addr_i(cpu_addr_i),
        .cpu_rwb_i(cpu_rwb_i),
        .cfg_i(cfg),
        .bus_o(bus_o)
    );

    assign cpu_be_o = cfg.cpu_be;
    assign status_o = cfg.status_led;
endmodule

`default_nettype wire

//--- rtl/pet_fpga_top.sv
//~~~~~~~~~~~~~~~~~~~~
// Board pin wrapper
// Active low pins converted to active high core signals
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pet_fpga_top import pet_pkg::*; #(
    parameter int unsigned SPI_SYNC_STAGES = 2
) (
    // FPGA
    input  logic        clock_i,        // System clock
    input  logic        rst_n_i,
    output logic        status_no,      // Status LED, 0 = on

    // CPU
    input  logic [15:0] cpu_addr_i,
    input  logic        cpu_rwb_i,      // 1 = read
    output logic        cpu_be_o,

    // RAM
    output logic        ram_addr_a16_o,
    output logic        ram_addr_a15_o,
    output logic        ram_addr_a11_o,
    output logic        ram_addr_a10_o,
    output logic        ram_oe_n_o,
    output logic        ram_we_n_o,

    // IO
    output logic        io_oe_n_o,
    output logic        pia1_cs_n_o,
    output logic        pia2_cs_n_o,
    output logic        via_cs_n_o,

    // SPI1 from the MCU
    input  logic        spi1_cs_ni,
    input  logic        spi1_sck_i,
    input  logic        spi1_sd_i,
    output logic        spi1_sd_o,

    // Board straps
    input  logic        config_crt_i,
    input  logic        config_kbd_i
);
    bus_ctl_t bus;
    logic     status;

    pet_main #(
        .SPI_SYNC_STAGES(SPI_SYNC_STAGES)
    ) main (
        .clock_i(clock_i),
        .rst_n_i(rst_n_i),
        .cpu_addr_i(cpu_addr_i),
        .cpu_rwb_i(cpu_rwb_i),
        .spi1_cs_ni(spi1_cs_ni),
        .spi1_sck_i(spi1_sck_i),
        .spi1_sd_i(spi1_sd_i),
        .config_crt_i(config_crt_i),
        .config_kbd_i(config_kbd_i),
        .bus_o(bus),
        .cpu_be_o(cpu_be_o),
        .status_o(status),
        .spi1_sd_o(spi1_sd_o)
    );

    // Strobes and selects are active low on the board
    assign ram_oe_n_o     = !bus.ram_oe;
    assign ram_we_n_o     = !bus.ram_we;
    assign io_oe_n_o      = !bus.io_oe;
    assign pia1_cs_n_o    = !bus.pia1_cs;
    assign pia2_cs_n_o    = !bus.pia2_cs;
    assign via_cs_n_o     = !bus.via_cs;
    assign status_no      = !status;

    assign ram_addr_a16_o = bus.ram_a16;   // Address bits keep their polarity
    assign ram_addr_a15_o = bus.ram_a15;
    assign ram_addr_a11_o = bus.ram_a11;
    assign ram_addr_a10_o = bus.ram_a10;
endmodule

`default_nettype wire

//--- sim/pet_fpga_tb.sv
//~~~~~~~~~~~~~~~~~~~~
// Testbench for the PET glue logic wrapper
// Clock, reset, SPI driver, check task, LFSR
// Stimulus table, random RAM/IO accesses, watchdog
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pet_fpga_tb import pet_pkg::*; ;
    localparam int SYNC_STAGES   = 2;
    localparam int SCK_HALF      = 4;                 // Clocks per SCK half period
    localparam int NUM_ROWS      = 19;
    localparam int NUM_RANDOM    = 32;
    localparam int WATCHDOG_CLKS = NUM_ROWS * 200 + 2000;

    // One table row
    // Pin order {ram_oe_n, ram_we_n, io_oe_n, pia1, pia2, via, a16, a15, a11, a10}
    typedef struct packed {
        logic        spi_wr;                          // Write REG_CTRL first
        logic [7:0]  ctrl;
        logic [15:0] addr;
        logic        rwb;
        logic [9:0]  pins;
    } row_t;

    logic        clock_i, rst_n_i;
    logic [15:0] cpu_addr_i;
    logic        cpu_rwb_i;
    logic        spi1_cs_ni, spi1_sck_i, spi1_sd_i;
    logic        config_crt_i, config_kbd_i;
    logic        status_no, cpu_be_o, spi1_sd_o;
    logic        ram_addr_a16_o, ram_addr_a15_o, ram_addr_a11_o, ram_addr_a10_o;
    logic        ram_oe_n_o, ram_we_n_o, io_oe_n_o;
    logic        pia1_cs_n_o, pia2_cs_n_o, via_cs_n_o;
    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr_q;
    logic [7:0]  last_ctrl;                           // Last value written to REG_CTRL

    pet_fpga_top #(
        .SPI_SYNC_STAGES(SYNC_STAGES)
    ) dut0 (
        .clock_i(clock_i), .rst_n_i(rst_n_i), .status_no(status_no),
        .cpu_addr_i(cpu_addr_i), .cpu_rwb_i(cpu_rwb_i), .cpu_be_o(cpu_be_o),
        .ram_addr_a16_o(ram_addr_a16_o), .ram_addr_a15_o(ram_addr_a15_o),
        .ram_addr_a11_o(ram_addr_a11_o), .ram_addr_a10_o(ram_addr_a10_o),
        .ram_oe_n_o(ram_oe_n_o), .ram_we_n_o(ram_we_n_o), .io_oe_n_o(io_oe_n_o),
        .pia1_cs_n_o(pia1_cs_n_o), .pia2_cs_n_o(pia2_cs_n_o), .via_cs_n_o(via_cs_n_o),
        .spi1_cs_ni(spi1_cs_ni), .spi1_sck_i(spi1_sck_i), .spi1_sd_i(spi1_sd_i),
        .spi1_sd_o(spi1_sd_o), .config_crt_i(config_crt_i), .config_kbd_i(config_kbd_i)
    );

    always #4 clock_i = !clock_i;                     // 8 ns period

    // Wait n rising edges and step past the last one to drive
    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock_i);
        #1;
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_pins(input logic [9:0] exp);
        check("ram_oe_n_o", 16'(ram_oe_n_o), 16'(exp[9]));
        check("ram_we_n_o", 16'(ram_we_n_o), 16'(exp[8]));
        check("io_oe_n_o", 16'(io_oe_n_o), 16'(exp[7]));
        check("pia1_cs_n_o", 16'(pia1_cs_n_o), 16'(exp[6]));
        check("pia2_cs_n_o", 16'(pia2_cs_n_o), 16'(exp[5]));
        check("via_cs_n_o", 16'(via_cs_n_o), 16'(exp[4]));
        check("ram_addr_a16_o", 16'(ram_addr_a16_o), 16'(exp[3]));
        check("ram_addr_a15_o", 16'(ram_addr_a15_o), 16'(exp[2]));
        check("ram_addr_a11_o", 16'(ram_addr_a11_o), 16'(exp[1]));
        check("ram_addr_a10_o", 16'(ram_addr_a10_o), 16'(exp[0]));
    endtask

    // Mode 0 transfer MSB first with read-back sampled on the SCK rise of bits 9 to 16
    task automatic spi_xfer(input logic [15:0] tx, output logic [7:0] rx);
        rx = '0;
        spi1_cs_ni = 1'b0;
        for (int i = 15; i >= 0; i--) begin
            spi1_sd_i = tx[i];
            wait_clocks(SCK_HALF);
            spi1_sck_i = 1'b1;
            if (i < 8) begin
                rx = {rx[6:0], spi1_sd_o};
            end
            wait_clocks(SCK_HALF);
            spi1_sck_i = 1'b0;
        end
        wait_clocks(SCK_HALF);
        spi1_cs_ni = 1'b1;
        wait_clocks(SCK_HALF);
    endtask

    task automatic write_ctrl(input logic [7:0] data);
        logic [7:0] unused_rx;
        spi_xfer({1'b1, REG_CTRL, data}, unused_rx);
        last_ctrl = data;
        wait_clocks(2 + SYNC_STAGES + 1);             // Write latency bound plus one
        check("cpu_be_o", 16'(cpu_be_o), 16'(data[0]));
        check("status_no", 16'(status_no), 16'(!data[3]));  // LED bit is bit 3
    endtask

    task automatic read_reg(input logic [6:0] addr, input logic [7:0] exp);
        logic [7:0] rx;
        spi_xfer({1'b0, addr, 8'h00}, rx);
        check("spi1_sd_o read-back", 16'(rx), 16'(exp));
    endtask

    task automatic apply_access(input logic [15:0] addr, input logic rwb, input logic [9:0] exp);
        cpu_addr_i = addr;
        cpu_rwb_i  = rwb;
        wait_clocks(1);                               // Decoder is one clock deep
        check_pins(exp);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[14:0], lfsr_q[0]};
        end
    endtask

    // Expected pins for RAM and IO accesses with the bus enabled
    function automatic logic [9:0] expect_pins(input logic [15:0] addr, input logic rwb);
        logic [9:0] pins;
        pins = 10'b111_111_0000;                      // Nothing selected
        if (addr <= RAM_END) begin
            pins[9] = !rwb;
            pins[8] = rwb;
            pins[2] = addr[15];
            pins[1] = addr[11];
            pins[0] = addr[10];
        end else if (addr >= IO_BASE && addr <= IO_END) begin
            pins[7] = 1'b0;
            // Each chip answers in the 16 bytes from its base
            pins[6] = !(addr >= PIA1_BASE && addr <= PIA1_BASE + 16'h000F);
            pins[5] = !(addr >= PIA2_BASE && addr <= PIA2_BASE + 16'h000F);
            pins[4] = !(addr >= VIA_BASE && addr <= VIA_BASE + 16'h000F);
        end
        return pins;
    endfunction

    task automatic load_rows();
        rows[0]  = '{1'b0, 8'h00, 16'h1234, 1'b1, 10'b111_111_0000};  // Bus still off
        rows[1]  = '{1'b0, 8'h00, 16'hE810, 1'b1, 10'b111_111_0000};
        rows[2]  = '{1'b1, 8'h03, 16'h1234, 1'b1, 10'b011_111_0000};  // cpu_be, rom_wp
        rows[3]  = '{1'b0, 8'h00, 16'h7C00, 1'b0, 10'b101_111_0011};
        rows[4]  = '{1'b0, 8'h00, 16'h0800, 1'b1, 10'b011_111_0010};
        rows[5]  = '{1'b0, 8'h00, 16'hE810, 1'b1, 10'b110_011_0000};  // PIA1
        rows[6]  = '{1'b0, 8'h00, 16'hE82F, 1'b0, 10'b110_101_0000};  // PIA2
        rows[7]  = '{1'b0, 8'h00, 16'hE84A, 1'b1, 10'b110_110_0000};  // VIA
        rows[8]  = '{1'b0, 8'h00, 16'hE800, 1'b1, 10'b110_111_0000};  // Gap
        rows[9]  = '{1'b0, 8'h00, 16'hE830, 1'b1, 10'b110_111_0000};
        rows[10] = '{1'b0, 8'h00, 16'hC000, 1'b0, 10'b111_111_1100};  // Protected
        rows[11] = '{1'b0, 8'h00, 16'hFC00, 1'b1, 10'b011_111_1111};
        rows[12] = '{1'b1, 8'h01, 16'hC000, 1'b0, 10'b101_111_1100};  // rom_wp off
        rows[13] = '{1'b0, 8'h00, 16'h9400, 1'b0, 10'b101_111_1101};
        rows[14] = '{1'b1, 8'h05, 16'h8C00, 1'b1, 10'b011_111_0100};  // Mirror on
        rows[15] = '{1'b0, 8'h00, 16'h8FFF, 1'b0, 10'b101_111_0100};
        rows[16] = '{1'b0, 8'h00, 16'h8400, 1'b1, 10'b011_111_0100};
        rows[17] = '{1'b1, 8'h01, 16'h8C00, 1'b1, 10'b011_111_0111};  // Mirror off
        rows[18] = '{1'b0, 8'h00, 16'h8800, 1'b1, 10'b011_111_0110};
    endtask

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clock_i);
        $display("Watchdog expired after %0d clocks, tests did not finish", WATCHDOG_CLKS);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [15:0] r;
        logic [15:0] sel;
        logic [15:0] addr;
        clock_i      = 1'b0;
        rst_n_i      = 1'b0;
        cpu_addr_i   = 16'h0000;
        cpu_rwb_i    = 1'b1;
        spi1_cs_ni   = 1'b1;                          // MCU idle
        spi1_sck_i   = 1'b0;
        spi1_sd_i    = 1'b0;
        config_crt_i = 1'b1;
        config_kbd_i = 1'b0;
        lfsr_q       = 16'd99;
        last_ctrl    = 8'h02;                         // Reset value with only rom_wp set
        load_rows();
        wait_clocks(10);
        rst_n_i = 1'b1;
        wait_clocks(2);

        // Reset state
        check_pins(10'b111_111_0000);
        check("cpu_be_o", 16'(cpu_be_o), 16'h0);
        check("status_no", 16'(status_no), 16'h1);
        check("spi1_sd_o", 16'(spi1_sd_o), 16'h0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].spi_wr) begin
                write_ctrl(rows[i].ctrl);
            end
            apply_access(rows[i].addr, rows[i].rwb, rows[i].pins);
        end

        // Register read-back and LED
        read_reg(REG_CTRL, last_ctrl);
        write_ctrl(8'h09);                            // cpu_be and status_led
        read_reg(REG_CTRL, 8'h09);
        read_reg(REG_STATUS, 8'h01);                  // {kbd, crt}
        config_crt_i = 1'b0;
        config_kbd_i = 1'b1;
        read_reg(REG_STATUS, 8'h02);
        read_reg(7'h05, 8'h00);                       // Unmapped

        // Random RAM and IO accesses
        for (int n = 0; n < NUM_RANDOM; n++) begin
            take_bits(2, sel);
            if (sel[1]) begin
                take_bits(15, r);
                addr = {1'b0, r[14:0]};
            end else begin
                take_bits(7, r);
                addr = IO_BASE + {9'd0, r[6:0]};      // Low IO page holds all windows
            end
            apply_access(addr, sel[0], expect_pins(addr, sel[0]));
        end

        $display("Simulation PASSED");
        $finish;
    end
endmodule

`default_nettype wire

//--- pet_fpga_top.f
rtl/pet_pkg.sv
rtl/spi_target.sv
rtl/pet_config_regs.sv
rtl/pet_addr_decode.sv
rtl/pet_main.sv
rtl/pet_fpga_top.sv
sim/pet_fpga_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PET glue logic testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module pet_fpga_tb -f pet_fpga_top.f \
    -o pet_fpga_sim &&
./obj_dir/pet_fpga_sim ||
{ echo "Build or run ended with an error"; exit 1; }
